/* build.f */
+incdir+include
design/sifhPkg.sv
design/histRam.sv
design/histBuilder.sv
design/peakFinder.sv
design/sifhControl.sv
design/sifhTop.sv
verification/sifh_sva.sv
verification/sifhTb.sv

/* Makefile */
# Verilator build and run of the histogram peak finder testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module sifhTb -Mdir obj_dir -o sifhSim
	./obj_dir/sifhSim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module sifhTb;

    localparam int NumRows    = 6;
    localparam int MaxCount   = (1 << `COUNT_WIDTH) - 1;
    localparam int CycleLimit = NumRows * (4 * `BIN_NUM + 2 * `FRAME_LEN * 4 + 50);

    logic             clk;
    logic             res;
    logic             start;
    sifhPkg::sample_t sample;
    sifhPkg::result_t result;
    logic             busy;

    // one row per frame with name, coarse target, fine target, target hits and noise spread
    string rowName   [NumRows] = '{"clean", "noise", "saturation", "tie", "backToBack",
                                   "cleanRepeat"};
    int    rowCoarse [NumRows] = '{17, 45, 3, 20, 63, 17};
    int    rowFine   [NumRows] = '{42, 9, 60, 33, 0, 42};
    int    rowHits   [NumRows] = '{30, 12, 40, 24, 48, 30};
    int    rowSpread [NumRows] = '{64, 64, 1, 0, 1, 64};

    integer                 seed = 32'h2f444ff8;
    int                     cycleCnt = 0;
    int                     hist [`BIN_NUM];     // reference histogram
    logic [`TIME_WIDTH-1:0] frame [`FRAME_LEN];  // timestamps of one pass

    sifhTop u_sifhTop (
        .clk    (clk),
        .res    (res),
        .start  (start),
        .sample (sample),
        .result (result),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= CycleLimit) begin
            $display("timeout, the measurements did not finish within %0d cycles", CycleLimit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;  // inputs change just after the edge
    endtask

    task automatic driveSample(input logic valid, input logic [`TIME_WIDTH-1:0] stamp);
        sample.valid     = valid;
        sample.timeStamp = stamp;
    endtask

    // hits land at random slots and noise lands around the coarse target
    task automatic makeFrame(input int r);
        int hitsLeft;
        int coarse;
        int fine;
        hitsLeft = rowHits[r];
        for (int i = 0; i < `FRAME_LEN; i++) begin
            if (($unsigned($random(seed)) % (`FRAME_LEN - i)) < hitsLeft) begin
                coarse   = rowCoarse[r];
                fine     = rowFine[r];
                hitsLeft = hitsLeft - 1;
            end else if (rowSpread[r] == 0) begin
                coarse = (rowCoarse[r] + 1) % `BIN_NUM;  // ties the next coarse bin
                fine   = rowFine[r];
            end else begin
                coarse = (rowCoarse[r] + $unsigned($random(seed)) % rowSpread[r]) % `BIN_NUM;
                fine   = $unsigned($random(seed)) % `BIN_NUM;
            end
            frame[i] = {`BIN_BITS'(coarse), `BIN_BITS'(fine)};
        end
    endtask

    task automatic clearHist();
        for (int b = 0; b < `BIN_NUM; b++) begin
            hist[b] = 0;
        end
    endtask

    task automatic addToHist(input int bin);
        if (hist[bin] < MaxCount) begin
            hist[bin] = hist[bin] + 1;
        end
    endtask

    // lowest bin wins a tie
    function automatic int bestBin();
        int best;
        best = 0;
        for (int b = 1; b < `BIN_NUM; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    task automatic checkField(input string testName, input string field,
                              input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s %s expected %0d actual %0d", testName, field, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // junk and one extra start until the DUT takes samples for this pass
    task automatic feedPass(input logic passSel, input logic [`TIME_WIDTH-1:0] junk);
        logic extraStart;
        extraStart = 1'b1;
        while (!((u_sifhTop.u_sifhControl.phase == sifhPkg::BUILD) &&
                 (u_sifhTop.u_sifhControl.pass == passSel) &&
                 (u_sifhTop.u_sifhControl.drainCnt == 2'd0))) begin
            start      = extraStart;
            extraStart = 1'b0;
            driveSample(1'b1, junk);
            nextCycle();
        end
        start = 1'b0;
        for (int i = 0; i < `FRAME_LEN; i++) begin
            driveSample(1'b1, frame[i]);
            nextCycle();
        end
        driveSample(1'b0, '0);
    endtask

    task automatic runRow(input int r);
        logic [`TIME_WIDTH-1:0] junk;
        int                     coarsePeak;
        int                     finePeak;
        sifhPkg::result_t       got;
        junk = {`BIN_BITS'((rowCoarse[r] + 32) % `BIN_NUM), `BIN_BITS'(rowFine[r])};
        while (busy) begin
            nextCycle();
        end
        repeat (4) begin  // dropped while idle
            driveSample(1'b1, junk);
            nextCycle();
        end
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        makeFrame(r);
        clearHist();
        for (int i = 0; i < `FRAME_LEN; i++) begin
            addToHist(frame[i][`TIME_WIDTH-1 -: `BIN_BITS]);
        end
        coarsePeak = bestBin();
        feedPass(1'b0, junk);
        makeFrame(r);
        clearHist();
        for (int i = 0; i < `FRAME_LEN; i++) begin
            if (int'(frame[i][`TIME_WIDTH-1 -: `BIN_BITS]) == coarsePeak) begin
                addToHist(frame[i][`BIN_BITS-1:0]);
            end
        end
        finePeak = bestBin();
        feedPass(1'b1, junk);
        while (!result.valid) begin
            driveSample(1'b1, junk);
            nextCycle();
        end
        got = result;
        driveSample(1'b0, '0);
        checkField(rowName[r], "coarseBin", coarsePeak, int'(got.coarseBin));
        checkField(rowName[r], "fineBin", finePeak, int'(got.fineBin));
        checkField(rowName[r], "peakCount", hist[finePeak], int'(got.peakCount));
    endtask

    initial begin
        res    = 1'b0;
        start  = 1'b0;
        sample = '0;
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        assert (!busy && !result.valid) else begin
            $display("busy or result valid is high right after reset");
            $display("Simulation failed");
            $fatal(1);
        end
        for (int r = 0; r < NumRows; r++) begin
            runRow(r);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/sifh_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhSva (
    input wire logic       clk,
    input wire logic       res,
    input wire logic       start,
    input wire logic       busy,
    input wire logic       resultValid,
    input wire logic       wrEn,
    input sifhPkg::phase_e phase
);

    aResultPulse: assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid)
        else $error("result valid stayed high for more than one cycle");

    aBusyAfterReset: assert property (@(posedge clk) ($rose(res) && !start) |=> !busy)
        else $error("busy went high after reset without a start");

    // busy drops only the cycle after the result
    aResultBusy: assert property (@(posedge clk) disable iff (!res)
        resultValid |-> busy)
        else $error("result valid while not busy");

    aNoWriteInFind: assert property (@(posedge clk) disable iff (!res)
        (phase == sifhPkg::FIND) |-> !wrEn)
        else $error("histogram RAM written during the peak scan");

endmodule

bind sifhTop sifhSva u_sifhSva (
    .clk         (clk),
    .res         (res),
    .start       (start),
    .busy        (busy),
    .resultValid (result.valid),
    .wrEn        (ramWr.en),
    .phase       (u_sifhControl.phase)
);

`default_nettype wire

/* design/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module sifhTop (
    input  wire logic        clk,
    input  wire logic        res,
    input  wire logic        start,
    input  sifhPkg::sample_t sample,
    output sifhPkg::result_t result,
    output logic             busy
);

    sifhPkg::ramWrite_t      ramWr;
    sifhPkg::ramRead_t       ramRd;
    sifhPkg::ramRead_t       builderRd;
    sifhPkg::ramRead_t       finderRd;
    sifhPkg::binReq_t        binReq;
    logic                    clearGo;
    logic                    clearDone;
    logic                    scanGo;
    logic                    peakValid;
    logic [`BIN_BITS-1:0]    peakBin;
    logic [`COUNT_WIDTH-1:0] peakCount;
    logic [`COUNT_WIDTH-1:0] rdData;   // shared by builder and finder

    sifhControl u_sifhControl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .sample    (sample),
        .clearDone (clearDone),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .builderRd (builderRd),
        .finderRd  (finderRd),
        .ramRd     (ramRd),
        .clearGo   (clearGo),
        .scanGo    (scanGo),
        .binReq    (binReq),
        .result    (result),
        .busy      (busy)
    );

    histBuilder u_histBuilder (
        .clk       (clk),
        .res       (res),
        .clearGo   (clearGo),
        .binReq    (binReq),
        .rdData    (rdData),
        .rd        (builderRd),
        .wr        (ramWr),
        .clearDone (clearDone)
    );

    peakFinder u_peakFinder (
        .clk       (clk),
        .res       (res),
        .scanGo    (scanGo),
        .rdData    (rdData),
        .rd        (finderRd),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    histRam u_histRam (
        .clk    (clk),
        .wr     (ramWr),
        .rd     (ramRd),
        .rdData (rdData)
    );

endmodule

`default_nettype wire

/* design/sifhControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module sifhControl (
    input  wire logic                    clk,
    input  wire logic                    res,
    input  wire logic                    start,
    input  sifhPkg::sample_t             sample,
    input  wire logic                    clearDone,
    input  wire logic                    peakValid,
    input  wire logic [`BIN_BITS-1:0]    peakBin,
    input  wire logic [`COUNT_WIDTH-1:0] peakCount,
    input  sifhPkg::ramRead_t            builderRd,
    input  sifhPkg::ramRead_t            finderRd,
    output sifhPkg::ramRead_t            ramRd,
    output logic                         clearGo,
    output logic                         scanGo,
    output sifhPkg::binReq_t             binReq,
    output sifhPkg::result_t             result,
    output logic                         busy
);

    localparam int CntBits = $clog2(`FRAME_LEN);
    localparam logic [CntBits-1:0] LastSample = CntBits'(`FRAME_LEN - 1);

    sifhPkg::phase_e         phase;
    logic                    pass;        // 0 coarse, 1 fine
    logic [CntBits-1:0]      sampleCnt;
    logic [1:0]              drainCnt;    // builder writes still in flight
    logic [`BIN_BITS-1:0]    coarsePeak;
    logic [`BIN_BITS-1:0]    fineBin;
    logic [`COUNT_WIDTH-1:0] fineCount;
    logic                    resultValid;
    logic [`BIN_BITS-1:0]    coarseBits;
    logic [`BIN_BITS-1:0]    fineBits;
    logic                    accept;
    logic                    inWindow;

    assign coarseBits = sample.timeStamp[`TIME_WIDTH-1 -: `BIN_BITS];
    assign fineBits   = sample.timeStamp[`TIME_WIDTH-1-`BIN_BITS -: `BIN_BITS];

    // every valid sample of the frame counts, pass 2 only forwards the window
    assign accept   = (phase == sifhPkg::BUILD) && (drainCnt == 2'd0) && sample.valid;
    assign inWindow = !pass || (coarseBits == coarsePeak);

    assign binReq.valid = accept && inWindow;
    assign binReq.bin   = pass ? fineBits : coarseBits;

    // finder owns the read port only while scanning
    always_comb begin
        if (phase == sifhPkg::FIND) begin
            ramRd = finderRd;
        end else begin
            ramRd = builderRd;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase       <= sifhPkg::IDLE;
            pass        <= 1'b0;
            busy        <= 1'b0;
            sampleCnt   <= '0;
            drainCnt    <= 2'd0;
            clearGo     <= 1'b0;
            scanGo      <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            clearGo     <= 1'b0;
            scanGo      <= 1'b0;
            resultValid <= 1'b0;
            if (resultValid) begin
                busy <= 1'b0;  // drops the cycle after the result
            end
            case (phase)
                sifhPkg::IDLE: begin
                    if (start && !busy) begin
                        phase   <= sifhPkg::CLEAR;
                        pass    <= 1'b0;
                        busy    <= 1'b1;
                        clearGo <= 1'b1;
                    end
                end
                sifhPkg::CLEAR: begin
                    if (clearDone) begin
                        phase     <= sifhPkg::BUILD;
                        sampleCnt <= '0;
                    end
                end
                sifhPkg::BUILD: begin
                    if (drainCnt != 2'd0) begin
                        drainCnt <= drainCnt - 2'd1;
                        if (drainCnt == 2'd1) begin
                            phase  <= sifhPkg::FIND;  // last write has landed
                            scanGo <= 1'b1;
                        end
                    end else if (accept) begin
                        sampleCnt <= sampleCnt + 1'b1;
                        if (sampleCnt == LastSample) begin
                            drainCnt <= 2'd2;
                        end
                    end
                end
                sifhPkg::FIND: begin
                    if (peakValid && !pass) begin
                        phase   <= sifhPkg::CLEAR;
                        pass    <= 1'b1;
                        clearGo <= 1'b1;
                    end else if (peakValid) begin
                        phase       <= sifhPkg::IDLE;
                        resultValid <= 1'b1;
                    end
                end
                default: phase <= sifhPkg::IDLE;
            endcase
        end
    end

    // peak payload of both passes
    always_ff @(posedge clk) begin
        if ((phase == sifhPkg::FIND) && peakValid) begin
            if (!pass) begin
                coarsePeak <= peakBin;
            end else begin
                fineBin   <= peakBin;
                fineCount <= peakCount;
            end
        end
    end

    assign result.valid     = resultValid;
    assign result.coarseBin = coarsePeak;
    assign result.fineBin   = fineBin;
    assign result.peakCount = fineCount;

endmodule

`default_nettype wire

/* design/peakFinder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module peakFinder (
    input  wire logic                    clk,
    input  wire logic                    res,
    input  wire logic                    scanGo,
    input  wire logic [`COUNT_WIDTH-1:0] rdData,
    output sifhPkg::ramRead_t            rd,
    output logic                         peakValid,
    output logic     [`BIN_BITS-1:0]     peakBin,
    output logic     [`COUNT_WIDTH-1:0]  peakCount
);

    localparam logic [`BIN_BITS-1:0] LastBin = `BIN_BITS'(`BIN_NUM - 1);

    logic                    scanning;
    logic [`BIN_BITS-1:0]    scanAddr;
    logic                    d1Valid;    // rdData belongs to d1Bin
    logic [`BIN_BITS-1:0]    d1Bin;
    logic [`BIN_BITS-1:0]    bestBin;
    logic [`COUNT_WIDTH-1:0] bestCount;

    assign rd.en   = scanning;
    assign rd.addr = scanAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            scanAddr  <= '0;
            d1Valid   <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            d1Valid   <= scanning;
            peakValid <= d1Valid && (d1Bin == LastBin);
            if (scanGo) begin
                scanning <= 1'b1;
                scanAddr <= '0;
            end else if (scanning) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == LastBin) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // bin 0 seeds the maximum, strictly greater keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        d1Bin <= scanAddr;
        if (d1Valid && ((d1Bin == '0) || (rdData > bestCount))) begin
            bestBin   <= d1Bin;
            bestCount <= rdData;
        end
    end

    assign peakBin   = bestBin;
    assign peakCount = bestCount;

endmodule

`default_nettype wire

/* design/histBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module histBuilder (
    input  wire logic                    clk,
    input  wire logic                    res,
    input  wire logic                    clearGo,
    input  sifhPkg::binReq_t             binReq,
    input  wire logic [`COUNT_WIDTH-1:0] rdData,
    output sifhPkg::ramRead_t            rd,
    output sifhPkg::ramWrite_t           wr,
    output logic                         clearDone
);

    localparam logic [`COUNT_WIDTH-1:0] MaxCount = '1;
    localparam logic [`BIN_BITS-1:0]    LastBin  = `BIN_BITS'(`BIN_NUM - 1);

    logic                    s1Valid;   // read data arrives this cycle
    logic [`BIN_BITS-1:0]    s1Bin;
    logic                    s2Valid;   // write to the RAM this cycle
    logic [`BIN_BITS-1:0]    s2Bin;
    logic [`COUNT_WIDTH-1:0] s2Data;
    logic                    s3Valid;   // written in the previous cycle
    logic [`BIN_BITS-1:0]    s3Bin;
    logic [`COUNT_WIDTH-1:0] s3Data;
    logic [`COUNT_WIDTH-1:0] baseCount;
    logic [`COUNT_WIDTH-1:0] nextCount;
    logic                    clearing;
    logic [`BIN_BITS-1:0]    clearAddr;

    // read issued in the request cycle
    assign rd.en   = binReq.valid;
    assign rd.addr = binReq.bin;

    // the RAM word is stale if one of the two newer writes hit the same bin
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            baseCount = s2Data;
        end else if (s3Valid && (s3Bin == s1Bin)) begin
            baseCount = s3Data;
        end else begin
            baseCount = rdData;
        end
    end

    assign nextCount = (baseCount == MaxCount) ? baseCount : baseCount + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= binReq.valid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= binReq.bin;
        s2Bin  <= s1Bin;
        s2Data <= nextCount;
        s3Bin  <= s2Bin;
        s3Data <= s2Data;
    end

    // zero sweep, done strobe one cycle after the last write
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing  <= 1'b0;
            clearAddr <= '0;
            clearDone <= 1'b0;
        end else begin
            clearDone <= clearing && (clearAddr == LastBin);
            if (clearGo) begin
                clearing  <= 1'b1;
                clearAddr <= '0;
            end else if (clearing) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == LastBin) begin
                    clearing <= 1'b0;
                end
            end
        end
    end

    assign wr.en   = clearing || s2Valid;
    assign wr.addr = clearing ? clearAddr : s2Bin;
    assign wr.data = clearing ? '0 : s2Data;

endmodule

`default_nettype wire

/* design/histRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sifh_consts.svh"

module histRam (
    input  wire logic                    clk,
    input  sifhPkg::ramWrite_t           wr,
    input  sifhPkg::ramRead_t            rd,
    output logic     [`COUNT_WIDTH-1:0] rdData
);

    // contents are undefined until the first clear sweep
    logic [`COUNT_WIDTH-1:0] mem [0:`BIN_NUM-1];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

/* design/sifhPkg.sv */
`default_nettype none

`include "sifh_consts.svh"

package sifhPkg;

    // one TDC sample, a strobe when valid
    typedef struct packed {
        logic                   valid;
        logic [`TIME_WIDTH-1:0] timeStamp;  // "time" is a reserved word
    } sample_t;

    // increment request towards the histogram builder
    typedef struct packed {
        logic                 valid;
        logic [`BIN_BITS-1:0] bin;
    } binReq_t;

    // SRAM write port
    typedef struct packed {
        logic                    en;
        logic [`BIN_BITS-1:0]    addr;
        logic [`COUNT_WIDTH-1:0] data;
    } ramWrite_t;

    // SRAM read port, data follows one cycle later
    typedef struct packed {
        logic                 en;
        logic [`BIN_BITS-1:0] addr;
    } ramRead_t;

    // measurement result, one cycle strobe
    typedef struct packed {
        logic                    valid;
        logic [`BIN_BITS-1:0]    coarseBin;
        logic [`BIN_BITS-1:0]    fineBin;
        logic [`COUNT_WIDTH-1:0] peakCount;
    } result_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        CLEAR = 2'd1,  // zero sweep of the SRAM
        BUILD = 2'd2,  // histogram accumulation
        FIND  = 2'd3   // peak scan
    } phase_e;

endpackage

`default_nettype wire

/* include/sifh_consts.svh */
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// timestamp from the TDC, coarse bits on top, fine bits below
`define TIME_WIDTH 12

// histogram geometry
`define BIN_BITS 6
`define BIN_NUM 64

// count width, saturates at 2**COUNT_WIDTH - 1
`define COUNT_WIDTH 5

// valid samples per histogram pass
`define FRAME_LEN 48

`endif
